//--- addr_gen.sv
// Steps while inactive are ignored; the address wraps modulo 2**AW without any error
`include "streamer_settings.svh"

module addr_gen (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     start_i,
  input  streamer_pkg::addr_ctrl_t ctrl_i,
  input  logic                     step_i,
  output logic [`STREAMER_AW-1:0]  addr_o,
  output logic                     active_o,
  output logic                     last_o
);

  logic [`STREAMER_AW-1:0]    addr_q;
  logic [`STREAMER_AW-1:0]    stride_q;
  logic [`STREAMER_LEN_W-1:0] remain_q;
  logic                       active_q;
  logic                       advance;

  assign advance = step_i && active_q;

  // Beat count and activity
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      active_q <= 1'b0;
      remain_q <= '0;
    end else if (start_i) begin
      // Zero length leaves the generator idle
      active_q <= (ctrl_i.length != '0);
      remain_q <= ctrl_i.length;
    end else if (advance) begin
      remain_q <= remain_q - 1'b1;
      if (last_o) begin
        active_q <= 1'b0;
      end
    end
  end

  // Address walk
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      addr_q   <= ctrl_i.base;
      stride_q <= ctrl_i.stride;
    end else if (advance) begin
      addr_q <= addr_q + stride_q;
    end
  end

  assign addr_o   = addr_q;
  assign active_o = active_q;
  assign last_o   = active_q && (remain_q == `STREAMER_LEN_W'd1);

endmodule

//--- filelist.f
+incdir+.
streamer_pkg.sv
stream_fifo.sv
addr_gen.sv
stream_source.sv
stream_sink.sv
mem_arbiter.sv
streamer_top.sv
tb_mem_model.sv
tb_streamer.sv

//--- mem_arbiter.sv
// Exactly two loads and one store; the store can starve the loads while it keeps requesting
`include "streamer_settings.svh"

module mem_arbiter (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  streamer_pkg::mem_req_t [1:0] ld_req_i,
  input  logic [1:0]                   ld_valid_i,
  output logic [1:0]                   ld_gnt_o,
  input  streamer_pkg::mem_req_t       st_req_i,
  input  logic                         st_valid_i,
  output logic                         st_gnt_o,
  output streamer_pkg::mem_req_t       mem_req_o,
  output logic                         mem_req_valid_o,
  input  logic                         mem_gnt_i,
  input  logic                         mem_rsp_valid_i,
  input  streamer_pkg::mem_rsp_t       mem_rsp_i,
  output logic [1:0]                   ld_rsp_valid_o,
  output streamer_pkg::mem_rsp_t       ld_rsp_o
);

  logic rr_q;
  logic ld_win;
  logic ld_sel;

  // Load under the pointer first, the other one if it is idle
  always_comb begin
    ld_win = rr_q;
    if (!ld_valid_i[rr_q]) begin
      ld_win = ~rr_q;
    end
  end

  // A pending store always owns the port
  assign ld_sel = !st_valid_i && (|ld_valid_i);

  assign mem_req_valid_o = st_valid_i || (|ld_valid_i);
  assign mem_req_o       = st_valid_i ? st_req_i : ld_req_i[ld_win];
  assign st_gnt_o        = st_valid_i && mem_gnt_i;

  for (genvar i = 0; i < 2; i++) begin : gen_ld_port
    assign ld_gnt_o[i] = ld_sel && mem_gnt_i && (ld_win == 1'(i));
    // Response goes back to the load that issued the tag
    assign ld_rsp_valid_o[i] = mem_rsp_valid_i && (mem_rsp_i.id == `STREAMER_ID_W'(i));
  end

  // Data is shared, only the valid is steered
  assign ld_rsp_o = mem_rsp_i;

  // Turn passes to the other load after each granted load
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_q <= 1'b0;
    end else if (ld_sel && mem_gnt_i) begin
      rr_q <= ~ld_win;
    end
  end

endmodule

//--- stream_fifo.sv
// Needs DEPTH of at least 2; a push while full or a pop while empty is dropped silently
module stream_fifo #(
  parameter type         T     = logic,
  parameter int unsigned DEPTH = 4
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       clear_i,
  input  logic                       push_i,
  input  T                           data_i,
  output logic                       full_o,
  input  logic                       pop_i,
  output T                           data_o,
  output logic                       empty_o,
  output logic [$clog2(DEPTH+1)-1:0] count_o
);

  typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
  typedef logic [$clog2(DEPTH+1)-1:0] count_t;

  T       mem_q [DEPTH];
  ptr_t   wr_ptr_q;
  ptr_t   rd_ptr_q;
  count_t count_q;
  logic   do_push;
  logic   do_pop;

  // Status straight from the registered fill level
  assign full_o  = (count_q == count_t'(DEPTH));
  assign empty_o = (count_q == '0);
  assign count_o = count_q;

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  // Head of the queue
  assign data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

//--- stream_sink.sv
// Beats beyond the job length are refused; writes leave in stream order, one per grant
`include "streamer_settings.svh"

module stream_sink #(
  parameter int unsigned ID = 2
) (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      start_i,
  input  streamer_pkg::addr_ctrl_t  ctrl_i,
  input  streamer_pkg::data_t       data_i,
  input  logic                      valid_i,
  output logic                      ready_o,
  output streamer_pkg::mem_req_t    req_o,
  output logic                      req_valid_o,
  input  logic                      gnt_i,
  output streamer_pkg::chan_flags_t flags_o
);

  logic [`STREAMER_AW-1:0]    wr_addr;
  logic                       ag_active;
  logic                       fifo_full;
  logic                       fifo_empty;
  logic                       accept;
  logic                       issue;
  streamer_pkg::mem_req_t     wr_req;
  logic [`STREAMER_LEN_W-1:0] writes_q;
  streamer_pkg::chan_flags_t  flags_q;

  addr_gen i_addr_gen (
    .clk_i    ( clk_i     ),
    .rst_n_i  ( rst_n_i   ),
    .start_i  ( start_i   ),
    .ctrl_i   ( ctrl_i    ),
    .step_i   ( accept    ),
    .addr_o   ( wr_addr   ),
    .active_o ( ag_active ),
    .last_o   (           )
  );

  // Back-pressure from the store queue
  assign ready_o = ag_active && !fifo_full;
  assign accept  = valid_i && ready_o;

  assign wr_req.addr  = wr_addr;
  assign wr_req.wen   = 1'b1;
  assign wr_req.wdata = data_i;
  assign wr_req.id    = `STREAMER_ID_W'(ID);

  stream_fifo #(
    .T     ( streamer_pkg::mem_req_t ),
    .DEPTH ( `STREAMER_STORE_DEPTH   )
  ) i_store_fifo (
    .clk_i   ( clk_i       ),
    .rst_n_i ( rst_n_i     ),
    .clear_i ( start_i     ),
    .push_i  ( accept      ),
    .data_i  ( wr_req      ),
    .full_o  ( fifo_full   ),
    .pop_i   ( issue       ),
    .data_o  ( req_o       ),
    .empty_o ( fifo_empty  ),
    .count_o (             )
  );

  assign req_valid_o = !fifo_empty;
  assign issue       = req_valid_o && gnt_i;

  // Job ends with the last granted write
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      flags_q  <= '0;
      writes_q <= '0;
    end else if (start_i) begin
      flags_q.busy <= (ctrl_i.length != '0);
      flags_q.done <= 1'b0;
      writes_q     <= ctrl_i.length;
    end else if (issue && flags_q.busy) begin
      writes_q <= writes_q - 1'b1;
      if (writes_q == `STREAMER_LEN_W'd1) begin
        flags_q.busy <= 1'b0;
        flags_q.done <= 1'b1;
      end
    end
  end

  assign flags_o = flags_q;

endmodule

//--- stream_source.sv
// One job at a time; a start during a running job may leave stale words from reads in flight
`include "streamer_settings.svh"

module stream_source #(
  parameter int unsigned ID = 0
) (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      start_i,
  input  streamer_pkg::addr_ctrl_t  ctrl_i,
  output streamer_pkg::mem_req_t    req_o,
  output logic                      req_valid_o,
  input  logic                      gnt_i,
  input  logic                      rsp_valid_i,
  input  streamer_pkg::mem_rsp_t    rsp_i,
  output streamer_pkg::data_t       data_o,
  output logic                      valid_o,
  input  logic                      ready_i,
  output streamer_pkg::chan_flags_t flags_o
);

  logic [`STREAMER_AW-1:0]                    rd_addr;
  logic                                       ag_active;
  logic [$clog2(`STREAMER_LOAD_DEPTH+1)-1:0] fifo_count;
  logic [$clog2(`STREAMER_LOAD_DEPTH+1)-1:0] pending_q;
  logic                                       fifo_empty;
  logic                                       issue;
  logic                                       pop;
  logic [`STREAMER_LEN_W-1:0]                 beats_q;
  streamer_pkg::chan_flags_t                  flags_q;

  addr_gen i_addr_gen (
    .clk_i    ( clk_i     ),
    .rst_n_i  ( rst_n_i   ),
    .start_i  ( start_i   ),
    .ctrl_i   ( ctrl_i    ),
    .step_i   ( issue     ),
    .addr_o   ( rd_addr   ),
    .active_o ( ag_active ),
    .last_o   (           )
  );

  // Every read in flight owns a FIFO slot, so responses always find room
  assign req_valid_o = ag_active && ((pending_q + fifo_count) < `STREAMER_LOAD_DEPTH);
  assign issue       = req_valid_o && gnt_i;

  assign req_o.addr  = rd_addr;
  assign req_o.wen   = 1'b0;
  assign req_o.wdata = '0;
  assign req_o.id    = `STREAMER_ID_W'(ID);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pending_q <= '0;
    end else if (issue && !rsp_valid_i) begin
      pending_q <= pending_q + 1'b1;
    end else if (!issue && rsp_valid_i) begin
      pending_q <= pending_q - 1'b1;
    end
  end

  // Response buffer, drained onto the output stream
  stream_fifo #(
    .T     ( streamer_pkg::data_t ),
    .DEPTH ( `STREAMER_LOAD_DEPTH )
  ) i_load_fifo (
    .clk_i   ( clk_i       ),
    .rst_n_i ( rst_n_i     ),
    .clear_i ( start_i     ),
    .push_i  ( rsp_valid_i ),
    .data_i  ( rsp_i.rdata ),
    .full_o  (             ),
    .pop_i   ( pop         ),
    .data_o  ( data_o      ),
    .empty_o ( fifo_empty  ),
    .count_o ( fifo_count  )
  );

  assign valid_o = !fifo_empty;
  assign pop     = valid_o && ready_i;

  // Delivered beats decide when the job ends
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      flags_q <= '0;
      beats_q <= '0;
    end else if (start_i) begin
      flags_q.busy <= (ctrl_i.length != '0);
      flags_q.done <= 1'b0;
      beats_q      <= ctrl_i.length;
    end else if (pop && flags_q.busy) begin
      beats_q <= beats_q - 1'b1;
      if (beats_q == `STREAMER_LEN_W'd1) begin
        flags_q.busy <= 1'b0;
        flags_q.done <= 1'b1;
      end
    end
  end

  assign flags_o = flags_q;

endmodule

//--- streamer_pkg.sv
// Shared types only; field widths come from the settings header and are not parameterizable
`include "streamer_settings.svh"

package streamer_pkg;

  // One memory word as it travels on the streams
  typedef logic [`STREAMER_DW-1:0] data_t;

  // Job for one channel
  // Stride is in bytes, length in beats
  typedef struct packed {
    logic [`STREAMER_AW-1:0]    base;
    logic [`STREAMER_AW-1:0]    stride;
    logic [`STREAMER_LEN_W-1:0] length;
  } addr_ctrl_t;

  // Request on the shared memory port
  typedef struct packed {
    logic [`STREAMER_AW-1:0]   addr;
    logic                      wen;    // 1 = write
    logic [`STREAMER_DW-1:0]   wdata;
    logic [`STREAMER_ID_W-1:0] id;
  } mem_req_t;

  // Read response
  // id echoes the tag of the granted read
  typedef struct packed {
    logic [`STREAMER_DW-1:0]   rdata;
    logic [`STREAMER_ID_W-1:0] id;
  } mem_rsp_t;

  // Channel status
  typedef struct packed {
    logic busy;
    logic done;
  } chan_flags_t;

endpackage

//--- streamer_settings.svh
// Fixed widths for the whole design; strides are byte offsets and must keep word alignment
`ifndef STREAMER_SETTINGS_SVH
`define STREAMER_SETTINGS_SVH

// Memory word width in bits
`define STREAMER_DW 32

// Byte address width
`define STREAMER_AW 32

// Channels sharing the memory port
// Tag 0 is X, tag 1 is W, tag 2 is Z
`define STREAMER_NUM_CH 3
`define STREAMER_ID_W 2

// Beat counters, so a job holds at most 2**16-1 beats
`define STREAMER_LEN_W 16

// Per-channel buffering
`define STREAMER_LOAD_DEPTH 4
`define STREAMER_STORE_DEPTH 2

`endif

//--- streamer_top.sv
// Memory must answer every granted read exactly one cycle later with the request's id
`include "streamer_settings.svh"

module streamer_top (
  input  logic                                           clk_i,
  input  logic                                           rst_n_i,
  input  logic                                           start_i,
  input  streamer_pkg::addr_ctrl_t                       x_ctrl_i,
  input  streamer_pkg::addr_ctrl_t                       w_ctrl_i,
  input  streamer_pkg::addr_ctrl_t                       z_ctrl_i,
  output streamer_pkg::data_t                            x_data_o,
  output logic                                           x_valid_o,
  input  logic                                           x_ready_i,
  output streamer_pkg::data_t                            w_data_o,
  output logic                                           w_valid_o,
  input  logic                                           w_ready_i,
  input  streamer_pkg::data_t                            z_data_i,
  input  logic                                           z_valid_i,
  output logic                                           z_ready_o,
  output streamer_pkg::mem_req_t                         mem_req_o,
  output logic                                           mem_req_valid_o,
  input  logic                                           mem_gnt_i,
  input  logic                                           mem_rsp_valid_i,
  input  streamer_pkg::mem_rsp_t                         mem_rsp_i,
  output streamer_pkg::chan_flags_t [`STREAMER_NUM_CH-1:0] flags_o
);

  // Load side, index 0 is X and 1 is W
  streamer_pkg::mem_req_t [1:0] ld_req;
  logic [1:0]                   ld_valid;
  logic [1:0]                   ld_gnt;
  logic [1:0]                   ld_rsp_valid;
  streamer_pkg::mem_rsp_t       ld_rsp;

  // Store side
  streamer_pkg::mem_req_t st_req;
  logic                   st_valid;
  logic                   st_gnt;

  stream_source #(.ID(0)) i_x_source (
    .clk_i       ( clk_i           ),
    .rst_n_i     ( rst_n_i         ),
    .start_i     ( start_i         ),
    .ctrl_i      ( x_ctrl_i        ),
    .req_o       ( ld_req[0]       ),
    .req_valid_o ( ld_valid[0]     ),
    .gnt_i       ( ld_gnt[0]       ),
    .rsp_valid_i ( ld_rsp_valid[0] ),
    .rsp_i       ( ld_rsp          ),
    .data_o      ( x_data_o        ),
    .valid_o     ( x_valid_o       ),
    .ready_i     ( x_ready_i       ),
    .flags_o     ( flags_o[0]      )
  );

  stream_source #(.ID(1)) i_w_source (
    .clk_i       ( clk_i           ),
    .rst_n_i     ( rst_n_i         ),
    .start_i     ( start_i         ),
    .ctrl_i      ( w_ctrl_i        ),
    .req_o       ( ld_req[1]       ),
    .req_valid_o ( ld_valid[1]     ),
    .gnt_i       ( ld_gnt[1]       ),
    .rsp_valid_i ( ld_rsp_valid[1] ),
    .rsp_i       ( ld_rsp          ),
    .data_o      ( w_data_o        ),
    .valid_o     ( w_valid_o       ),
    .ready_i     ( w_ready_i       ),
    .flags_o     ( flags_o[1]      )
  );

  stream_sink #(.ID(2)) i_z_sink (
    .clk_i       ( clk_i      ),
    .rst_n_i     ( rst_n_i    ),
    .start_i     ( start_i    ),
    .ctrl_i      ( z_ctrl_i   ),
    .data_i      ( z_data_i   ),
    .valid_i     ( z_valid_i  ),
    .ready_o     ( z_ready_o  ),
    .req_o       ( st_req     ),
    .req_valid_o ( st_valid   ),
    .gnt_i       ( st_gnt     ),
    .flags_o     ( flags_o[2] )
  );

  mem_arbiter i_mem_arbiter (
    .clk_i           ( clk_i           ),
    .rst_n_i         ( rst_n_i         ),
    .ld_req_i        ( ld_req          ),
    .ld_valid_i      ( ld_valid        ),
    .ld_gnt_o        ( ld_gnt          ),
    .st_req_i        ( st_req          ),
    .st_valid_i      ( st_valid        ),
    .st_gnt_o        ( st_gnt          ),
    .mem_req_o       ( mem_req_o       ),
    .mem_req_valid_o ( mem_req_valid_o ),
    .mem_gnt_i       ( mem_gnt_i       ),
    .mem_rsp_valid_i ( mem_rsp_valid_i ),
    .mem_rsp_i       ( mem_rsp_i       ),
    .ld_rsp_valid_o  ( ld_rsp_valid    ),
    .ld_rsp_o        ( ld_rsp          )
  );

endmodule

//--- tb_mem_model.sv
// Grants about 70 % of cycles at random; unwritten words read as addr XOR 32'hA5A5_0000
`include "streamer_settings.svh"

module tb_mem_model (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  streamer_pkg::mem_req_t  mem_req_i,
  input  logic                    mem_req_valid_i,
  output logic                    mem_gnt_o,
  output logic                    mem_rsp_valid_o,
  output streamer_pkg::mem_rsp_t  mem_rsp_o,
  output logic                    wr_seen_o,
  output logic [`STREAMER_AW-1:0] wr_addr_o,
  output logic [`STREAMER_DW-1:0] wr_data_o
);

  timeunit 1ns;
  timeprecision 100ps;

  // Written words by byte address, on top of the fill pattern
  logic [`STREAMER_DW-1:0] written [logic [`STREAMER_AW-1:0]];

  // Transfer that crosses the port at the coming rising edge
  logic                   rd_pend;
  streamer_pkg::mem_rsp_t rd_rsp;
  logic                   wr_pend;
  streamer_pkg::mem_req_t wr_req;

  function automatic logic [`STREAMER_DW-1:0] read_word(input logic [`STREAMER_AW-1:0] addr);
    logic [`STREAMER_DW-1:0] word;
    word = addr ^ 32'hA5A5_0000;
    if (written.exists(addr)) begin
      word = written[addr];
    end
    return word;
  endfunction

  initial begin
    mem_gnt_o       = 1'b0;
    mem_rsp_valid_o = 1'b0;
    mem_rsp_o       = '0;
    wr_seen_o       = 1'b0;
    wr_addr_o       = '0;
    wr_data_o       = '0;
    rd_pend         = 1'b0;
    rd_rsp          = '0;
    wr_pend         = 1'b0;
    wr_req          = '0;
  end

  always @(negedge clk_i) begin : port_step
    logic gnt;
    // Results of the transfer at the last rising edge, one cycle after grant
    mem_rsp_valid_o <= rd_pend;
    mem_rsp_o       <= rd_rsp;
    wr_seen_o       <= wr_pend;
    wr_addr_o       <= wr_req.addr;
    wr_data_o       <= wr_req.wdata;
    rd_pend = 1'b0;
    wr_pend = 1'b0;
    gnt = rst_n_i && (($urandom % 10) < 7);
    mem_gnt_o <= gnt;
    // Request and valid come from DUT registers, so they are settled here
    if (mem_req_valid_i && gnt) begin
      if (mem_req_i.wen) begin
        written[mem_req_i.addr] = mem_req_i.wdata;
        wr_pend = 1'b1;
        wr_req  = mem_req_i;
      end else begin
        rd_pend      = 1'b1;
        rd_rsp.rdata = read_word(mem_req_i.addr);
        rd_rsp.id    = mem_req_i.id;
      end
    end
  end

endmodule

//--- tb_streamer.sv
// Z jobs must stay clear of the X and W ranges, since load checks assume unwritten words
`include "streamer_settings.svh"

module tb_streamer;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned X_ALONE_LEN = 8;
  localparam int unsigned X_DUAL_LEN  = 12;
  localparam int unsigned W_DUAL_LEN  = 10;
  localparam int unsigned Z_ALONE_LEN = 10;
  localparam int unsigned MIXED_LEN   = 16;
  localparam int unsigned TOTAL_BEATS =
    X_ALONE_LEN + X_DUAL_LEN + W_DUAL_LEN + Z_ALONE_LEN + 3 * MIXED_LEN;
  localparam int unsigned CYCLE_LIMIT = 40 * TOTAL_BEATS + 200;

  logic                                             clk;
  logic                                             rst_n;
  logic                                             start;
  streamer_pkg::addr_ctrl_t                         x_ctrl;
  streamer_pkg::addr_ctrl_t                         w_ctrl;
  streamer_pkg::addr_ctrl_t                         z_ctrl;
  streamer_pkg::data_t                              x_data;
  logic                                             x_valid;
  logic                                             x_ready;
  streamer_pkg::data_t                              w_data;
  logic                                             w_valid;
  logic                                             w_ready;
  streamer_pkg::data_t                              z_data;
  logic                                             z_valid;
  logic                                             z_ready;
  streamer_pkg::mem_req_t                           mem_req;
  logic                                             mem_req_valid;
  logic                                             mem_gnt;
  logic                                             mem_rsp_valid;
  streamer_pkg::mem_rsp_t                           mem_rsp;
  streamer_pkg::chan_flags_t [`STREAMER_NUM_CH-1:0] flags;
  logic                                             wr_seen;
  logic [`STREAMER_AW-1:0]                          wr_addr;
  logic [`STREAMER_DW-1:0]                          wr_data;

  // Expected beats are filled before each start and taken by the compare process
  logic [`STREAMER_DW-1:0] exp_x_q [$];
  logic [`STREAMER_DW-1:0] exp_w_q [$];
  logic [`STREAMER_AW-1:0] exp_z_addr_q [$];
  logic [`STREAMER_DW-1:0] exp_z_data_q [$];
  logic                    rand_ready;
  int unsigned             cycles;

  streamer_top u_streamer_top (
    .clk_i           ( clk           ),
    .rst_n_i         ( rst_n         ),
    .start_i         ( start         ),
    .x_ctrl_i        ( x_ctrl        ),
    .w_ctrl_i        ( w_ctrl        ),
    .z_ctrl_i        ( z_ctrl        ),
    .x_data_o        ( x_data        ),
    .x_valid_o       ( x_valid       ),
    .x_ready_i       ( x_ready       ),
    .w_data_o        ( w_data        ),
    .w_valid_o       ( w_valid       ),
    .w_ready_i       ( w_ready       ),
    .z_data_i        ( z_data        ),
    .z_valid_i       ( z_valid       ),
    .z_ready_o       ( z_ready       ),
    .mem_req_o       ( mem_req       ),
    .mem_req_valid_o ( mem_req_valid ),
    .mem_gnt_i       ( mem_gnt       ),
    .mem_rsp_valid_i ( mem_rsp_valid ),
    .mem_rsp_i       ( mem_rsp       ),
    .flags_o         ( flags         )
  );

  tb_mem_model u_mem (
    .clk_i           ( clk           ),
    .rst_n_i         ( rst_n         ),
    .mem_req_i       ( mem_req       ),
    .mem_req_valid_i ( mem_req_valid ),
    .mem_gnt_o       ( mem_gnt       ),
    .mem_rsp_valid_o ( mem_rsp_valid ),
    .mem_rsp_o       ( mem_rsp       ),
    .wr_seen_o       ( wr_seen       ),
    .wr_addr_o       ( wr_addr       ),
    .wr_data_o       ( wr_data       )
  );

  always #50 clk = ~clk;

  // Content of any word the store channel never wrote
  function automatic logic [`STREAMER_DW-1:0] mem_word(input logic [`STREAMER_AW-1:0] addr);
    return addr ^ 32'hA5A5_0000;
  endfunction

  function automatic streamer_pkg::addr_ctrl_t make_ctrl(input logic [`STREAMER_AW-1:0] base,
                                                         input logic [`STREAMER_AW-1:0] stride,
                                                         input int unsigned len);
    streamer_pkg::addr_ctrl_t c;
    c.base   = base;
    c.stride = stride;
    c.length = `STREAMER_LEN_W'(len);
    return c;
  endfunction

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("** FAIL **");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("Fail %s: got 0x%08h expected 0x%08h", name, got, exp));
    end
  endtask

  function automatic logic job_finished(input streamer_pkg::addr_ctrl_t xc,
                                        input streamer_pkg::addr_ctrl_t wc,
                                        input streamer_pkg::addr_ctrl_t zc);
    return (xc.length == 0 || flags[0].done) && (wc.length == 0 || flags[1].done) &&
           (zc.length == 0 || flags[2].done);
  endfunction

  // Ready stays high unless a job asks for random back-pressure
  always @(negedge clk) begin
    if (rand_ready) begin
      x_ready <= (($urandom % 3) != 0);
      w_ready <= (($urandom % 3) != 0);
    end else begin
      x_ready <= 1'b1;
      w_ready <= 1'b1;
    end
  end

  // Compare every transfer against the expected queues
  always @(posedge clk) begin
    if (rst_n) begin
      if (x_valid && x_ready) begin
        if (exp_x_q.size() == 0) begin
          abort_run("X stream delivered a beat that was not expected");
        end
        check_value("x_data_o", x_data, exp_x_q.pop_front());
      end
      if (w_valid && w_ready) begin
        if (exp_w_q.size() == 0) begin
          abort_run("W stream delivered a beat that was not expected");
        end
        check_value("w_data_o", w_data, exp_w_q.pop_front());
      end
      if (wr_seen) begin
        if (exp_z_addr_q.size() == 0) begin
          abort_run("Memory received a write that was not expected");
        end
        check_value("mem_req_o.addr", wr_addr, exp_z_addr_q.pop_front());
        check_value("mem_req_o.wdata", wr_data, exp_z_data_q.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > CYCLE_LIMIT) begin
      abort_run($sformatf("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT));
    end
  end

  task automatic check_idle_after_reset();
    int unsigned n;
    for (n = 0; n < 4; n++) begin
      @(negedge clk);
      check_value("flags_o", flags, '0);
      check_value("x_valid_o", x_valid, 1'b0);
      check_value("w_valid_o", w_valid, 1'b0);
      check_value("mem_req_valid_o", mem_req_valid, 1'b0);
    end
  endtask

  task automatic run_job(input streamer_pkg::addr_ctrl_t xc, input streamer_pkg::addr_ctrl_t wc,
                         input streamer_pkg::addr_ctrl_t zc, input logic rnd);
    logic [`STREAMER_DW-1:0] z_words [$];
    int unsigned             k;
    for (k = 0; k < xc.length; k++) begin
      exp_x_q.push_back(mem_word(xc.base + xc.stride * k));
    end
    for (k = 0; k < wc.length; k++) begin
      exp_w_q.push_back(mem_word(wc.base + wc.stride * k));
    end
    for (k = 0; k < zc.length; k++) begin
      z_words.push_back($urandom);
      exp_z_addr_q.push_back(zc.base + zc.stride * k);
      exp_z_data_q.push_back(z_words[k]);
    end
    @(negedge clk);
    start      <= 1'b1;
    x_ctrl     <= xc;
    w_ctrl     <= wc;
    z_ctrl     <= zc;
    rand_ready <= rnd;
    @(negedge clk);
    start <= 1'b0;
    check_value("flags_o[0].busy", flags[0].busy, xc.length != 0);
    check_value("flags_o[1].busy", flags[1].busy, wc.length != 0);
    check_value("flags_o[2].busy", flags[2].busy, zc.length != 0);
    check_value("flags_o[0].done", flags[0].done, 1'b0);
    check_value("flags_o[1].done", flags[1].done, 1'b0);
    check_value("flags_o[2].done", flags[2].done, 1'b0);
    // Z beats go out in order with idle gaps in random mode
    for (k = 0; k < zc.length; k++) begin
      while (rnd && (($urandom % 4) == 0)) begin
        z_valid <= 1'b0;
        @(negedge clk);
      end
      z_valid <= 1'b1;
      z_data  <= z_words[k];
      @(posedge clk);
      while (!z_ready) begin
        @(posedge clk);
      end
      @(negedge clk);
    end
    z_valid <= 1'b0;
    while (!job_finished(xc, wc, zc)) begin
      @(negedge clk);
    end
    rand_ready <= 1'b0;
    // Last write shows up at the model one cycle after Z done
    repeat (2) @(negedge clk);
    if (exp_x_q.size() != 0 || exp_w_q.size() != 0 || exp_z_addr_q.size() != 0) begin
      abort_run("A channel reported done with beats still missing");
    end
    check_value("flags_o[0].busy", flags[0].busy, 1'b0);
    check_value("flags_o[1].busy", flags[1].busy, 1'b0);
    check_value("flags_o[2].busy", flags[2].busy, 1'b0);
    // Done holds until the next start
    check_value("flags_o[0].done", flags[0].done, xc.length != 0);
    check_value("flags_o[1].done", flags[1].done, wc.length != 0);
    check_value("flags_o[2].done", flags[2].done, zc.length != 0);
    check_value("x_valid_o", x_valid, 1'b0);
    check_value("w_valid_o", w_valid, 1'b0);
  endtask

  initial begin
    void'($urandom(32'h3e60_1712));
    clk        = 1'b0;
    rst_n      = 1'b0;
    start      = 1'b0;
    x_ctrl     = '0;
    w_ctrl     = '0;
    z_ctrl     = '0;
    x_ready    = 1'b1;
    w_ready    = 1'b1;
    z_valid    = 1'b0;
    z_data     = '0;
    rand_ready = 1'b0;
    cycles     = 0;
    repeat (8) @(negedge clk);
    rst_n <= 1'b1;
    check_idle_after_reset();
    // X alone
    run_job(make_ctrl(32'h1000, 32'd4, X_ALONE_LEN), make_ctrl(0, 0, 0), make_ctrl(0, 0, 0), 1'b0);
    // X and W together share the port by tag
    run_job(make_ctrl(32'h2000, 32'd8, X_DUAL_LEN), make_ctrl(32'h3000, 32'd12, W_DUAL_LEN),
            make_ctrl(0, 0, 0), 1'b0);
    // Z store alone
    run_job(make_ctrl(0, 0, 0), make_ctrl(0, 0, 0), make_ctrl(32'h8000, 32'd4, Z_ALONE_LEN), 1'b0);
    // All three under back-pressure
    run_job(make_ctrl(32'h4000, 32'd4, MIXED_LEN), make_ctrl(32'h5000, 32'd16, MIXED_LEN),
            make_ctrl(32'h9000, 32'd8, MIXED_LEN), 1'b1);
    $display("** PASS **");
    $finish;
  end

endmodule
